// ==== verilog.f ====
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/dp_ctrl_if.sv
src/alu.sv
src/datapath.sv
src/idecoder.sv
src/controller.sv
src/cpu.sv
src/ram.sv
src/cpu_top.sv
sim/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_cpu_top.sv ====
`timescale 1ns/10ps

module tb_cpu_top;

  localparam int NUM_TESTS = 6;
  localparam int RUN_LIMIT = 32 * 8;

  logic           clk;
  logic           rst_n;
  logic           prog_w_en;
  isa_pkg::addr_t start_pc;
  isa_pkg::addr_t prog_addr;
  isa_pkg::word_t prog_data;
  isa_pkg::word_t out;
  logic           z;
  logic           n;
  logic           v;
  logic           halted;

  // program image as the tb sees it, plus the words actually loaded
  isa_pkg::word_t image [256];
  isa_pkg::addr_t load_list [$];
  isa_pkg::addr_t cursor;
  isa_pkg::addr_t prog_start;
  logic [31:0]    lcg_state;

  string          test_name;
  int             test_errors;
  int             total_errors;
  int             tests_run;
  int             tests_failed;
  isa_pkg::word_t exp_out;
  logic [2:0]     exp_flags;
  bit             exp_flags_set;
  event           compare_ev;
  int             compare_ack;

  cpu_top i_dut (
    .clk(clk), .rst_n(rst_n), .start_pc(start_pc), .prog_w_en(prog_w_en),
    .prog_addr(prog_addr), .prog_data(prog_data),
    .out(out), .z(z), .n(n), .v(v), .halted(halted)
  );

  always #20 clk = ~clk;

  function automatic int rnd(int range);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'({8'b0, lcg_state[31:8]}) % range;
  endfunction

  // instruction encoders
  function automatic isa_pkg::word_t enc_mov_imm(logic [2:0] rn, logic [7:0] imm);
    return {3'b110, 2'b10, rn, imm};
  endfunction

  function automatic isa_pkg::word_t enc_mov_reg(logic [2:0] rd, logic [2:0] rm,
                                                 logic [1:0] sh);
    return {3'b110, 2'b00, 3'b000, rd, sh, rm};
  endfunction

  function automatic isa_pkg::word_t enc_alu(logic [1:0] op, logic [2:0] rn, logic [2:0] rd,
                                             logic [1:0] sh, logic [2:0] rm);
    return {3'b101, op, rn, rd, sh, rm};
  endfunction

  function automatic isa_pkg::word_t enc_mem(logic [2:0] opc, logic [2:0] rn, logic [2:0] rd,
                                             logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};
  endfunction

  function automatic isa_pkg::word_t shift_one(isa_pkg::word_t x, logic [1:0] sh);
    case (sh)
      2'd1:    return x << 1;
      2'd2:    return x >> 1;
      2'd3:    return $signed(x) >>> 1;
      default: return x;
    endcase
  endfunction

  // ISA model, runs from start until HALT
  function automatic void ref_run(input isa_pkg::addr_t start, output isa_pkg::word_t res,
                                  output logic [2:0] flags, output bit flags_set);
    isa_pkg::word_t mem [256];
    isa_pkg::word_t r [8];
    isa_pkg::word_t c;
    isa_pkg::word_t ins;
    isa_pkg::word_t opb;
    isa_pkg::word_t ea;
    isa_pkg::word_t d;
    isa_pkg::addr_t pc;
    int             diff;
    int             steps;
    bit             done;
    for (int i = 0; i < 256; i++) begin
      mem[i] = image[i];
    end
    c = 'x;
    flags = 'x;
    flags_set = 1'b0;
    pc = start;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 64) begin
      ins = mem[pc];
      pc = pc + 8'd1;
      steps++;
      opb = shift_one(r[ins[2:0]], ins[4:3]);
      ea = r[ins[10:8]] + {{11{ins[4]}}, ins[4:0]};
      case (ins[15:13])
        3'b110: begin
          if (ins[12:11] == 2'b10) begin
            r[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
          end else begin
            c = opb;
            r[ins[7:5]] = c;
          end
        end
        3'b101: begin
          case (ins[12:11])
            2'b00: c = r[ins[10:8]] + opb;
            2'b10: c = r[ins[10:8]] & opb;
            2'b11: c = ~opb;
            default: begin
              diff = $signed(r[ins[10:8]]) - $signed(opb);
              d = diff[15:0];
              flags = {d == 16'h0, d[15], (diff > 32767) || (diff < -32768)};
              flags_set = 1'b1;
            end
          endcase
          if (ins[12:11] != 2'b01) begin
            r[ins[7:5]] = c;
          end
        end
        3'b011: begin
          c = ea;
          r[ins[7:5]] = mem[ea[7:0]];
        end
        3'b100: begin
          c = r[ins[7:5]];
          mem[ea[7:0]] = c;
        end
        default: done = 1'b1;
      endcase
    end
    res = c;
  endfunction

  task automatic check_value(string what, isa_pkg::word_t expected, isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic new_image(isa_pkg::addr_t start);
    for (int a = 0; a < 256; a++) begin
      image[a] = {8'(a) ^ 8'h5a, 8'(a)};
    end
    load_list.delete();
    cursor = start;
    prog_start = start;
  endtask

  task automatic emit(isa_pkg::word_t w);
    image[cursor] = w;
    load_list.push_back(cursor);
    cursor = cursor + 8'd1;
  endtask

  task automatic put_data(isa_pkg::addr_t a, isa_pkg::word_t w);
    image[a] = w;
    load_list.push_back(a);
  endtask

  // holds the core in reset and writes the listed words
  task automatic load_image();
    @(posedge clk);
    rst_n <= 1'b0;
    prog_w_en <= 1'b0;
    start_pc <= prog_start;
    @(posedge clk);
    foreach (load_list[i]) begin
      @(posedge clk);
      prog_w_en <= 1'b1;
      prog_addr <= load_list[i];
      prog_data <= image[load_list[i]];
    end
    @(posedge clk);
    prog_w_en <= 1'b0;
  endtask

  task automatic wait_halted(output bit ok);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (halted !== 1'b1 && cycles < RUN_LIMIT);
    ok = (halted === 1'b1);
    if (!ok) begin
      $display("error in %s: halted did not rise within %0d cycles", test_name, RUN_LIMIT);
      test_errors++;
    end
  endtask

  task automatic run_and_compare();
    int req;
    bit ok;
    load_image();
    @(posedge clk);
    rst_n <= 1'b1;
    wait_halted(ok);
    if (ok) begin
      ref_run(prog_start, exp_out, exp_flags, exp_flags_set);
      req = compare_ack + 1;
      -> compare_ev;
      wait (compare_ack == req);
    end
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // r7 is the data base, 0x60..0x7f holds data
  task automatic build_random_program(int count);
    new_image(8'(rnd(32)));
    for (int a = 8'h60; a < 8'h80; a++) begin
      put_data(8'(a), 16'(rnd(65536)));
    end
    for (int r = 0; r < 7; r++) begin
      emit(enc_mov_imm(3'(r), 8'(rnd(256))));
    end
    emit(enc_mov_imm(3'd7, 8'h70));
    for (int k = 0; k < count; k++) begin
      case (rnd(8))
        0: emit(enc_mov_imm(3'(rnd(7)), 8'(rnd(256))));
        1: emit(enc_mov_reg(3'(rnd(7)), 3'(rnd(8)), 2'(rnd(4))));
        2: emit(enc_alu(2'b00, 3'(rnd(8)), 3'(rnd(7)), 2'(rnd(4)), 3'(rnd(8))));
        3: emit(enc_alu(2'b10, 3'(rnd(8)), 3'(rnd(7)), 2'(rnd(4)), 3'(rnd(8))));
        4: emit(enc_alu(2'b11, 3'(rnd(8)), 3'(rnd(7)), 2'(rnd(4)), 3'(rnd(8))));
        5: emit(enc_alu(2'b01, 3'(rnd(8)), 3'd0, 2'(rnd(4)), 3'(rnd(8))));
        6: emit(enc_mem(3'b011, 3'd7, 3'(rnd(7)), 5'(rnd(32))));
        default: emit(enc_mem(3'b100, 3'd7, 3'(rnd(8)), 5'(rnd(32))));
      endcase
    end
    emit(enc_alu(2'b01, 3'(rnd(8)), 3'd0, 2'(rnd(4)), 3'(rnd(8))));
    emit(enc_mov_reg(3'd0, 3'(rnd(8)), 2'd0));
    emit(16'he000);
  endtask

  initial begin
    forever begin
      @(compare_ev);
      check_value("out", exp_out, out);
      if (exp_flags_set) begin
        check_value("flags znv", {13'b0, exp_flags}, {13'b0, z, n, v});
      end
      compare_ack = compare_ack + 1;
    end
  end

  initial begin
    #(NUM_TESTS * 32 * 8 * 40);
    $display("error: watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [7:0] val;
    logic [7:0] addr;
    int         i1;
    int         i2;
    clk = 1'b0;
    rst_n = 1'b0;
    start_pc = '0;
    prog_w_en = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lcg_state = 32'd40293;
    compare_ack = 0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;

    begin_test("mov_shift");
    for (int sh = 0; sh < 4; sh++) begin
      val = 8'(rnd(256));
      // asr case gets a negative value
      if (sh == 3) begin
        val[7] = 1'b1;
      end
      new_image(8'(rnd(64)));
      emit(enc_mov_imm(3'd1, val));
      emit(enc_mov_reg(3'd2, 3'd1, 2'(sh)));
      emit(enc_mov_reg(3'd3, 3'd2, 2'd0));
      emit(16'he000);
      run_and_compare();
    end
    end_test();

    begin_test("add_and_mvn");
    for (int k = 0; k < 3; k++) begin
      new_image(8'(rnd(64)));
      emit(enc_mov_imm(3'd1, 8'(rnd(256))));
      emit(enc_mov_imm(3'd2, 8'(rnd(256))));
      emit(enc_alu(k == 0 ? 2'b00 : (k == 1 ? 2'b10 : 2'b11), 3'd1, 3'd3, 2'(rnd(4)), 3'd2));
      emit(enc_mov_reg(3'd4, 3'd3, 2'd0));
      emit(16'he000);
      run_and_compare();
    end
    end_test();

    begin_test("cmp_flags");
    val = 8'(rnd(256));
    new_image(8'(rnd(64)));
    emit(enc_mov_imm(3'd1, val));
    emit(enc_mov_imm(3'd2, val));
    emit(enc_alu(2'b01, 3'd1, 3'd0, 2'd0, 3'd2));
    emit(enc_mov_reg(3'd3, 3'd1, 2'd0));
    emit(16'he000);
    run_and_compare();
    val = 8'(rnd(64));
    new_image(8'(rnd(64)));
    emit(enc_mov_imm(3'd1, val));
    emit(enc_mov_imm(3'd2, val + 8'd1 + 8'(rnd(63))));
    emit(enc_alu(2'b01, 3'd1, 3'd0, 2'd0, 3'd2));
    emit(enc_mov_reg(3'd3, 3'd1, 2'd0));
    emit(16'he000);
    run_and_compare();
    // 0xff80 shifted left eight times gives 0x8000
    new_image(8'(rnd(64)));
    emit(enc_mov_imm(3'd1, 8'h80));
    for (int s = 0; s < 8; s++) begin
      emit(enc_mov_reg(3'd1, 3'd1, 2'd1));
    end
    emit(enc_mov_imm(3'd2, 8'd1 + 8'(rnd(127))));
    emit(enc_alu(2'b01, 3'd1, 3'd0, 2'd0, 3'd2));
    emit(enc_mov_reg(3'd3, 3'd1, 2'd0));
    emit(16'he000);
    run_and_compare();
    end_test();

    begin_test("str_ldr");
    for (int k = 0; k < 2; k++) begin
      addr = 8'h60 + 8'(rnd(16));
      i1 = (k == 1) ? -(1 + rnd(16)) : rnd(16);
      i2 = -(1 + rnd(16));
      new_image(8'(rnd(64)));
      put_data(addr, image[addr]);
      emit(enc_mov_imm(3'd1, addr - 8'(i1)));
      emit(enc_mov_imm(3'd4, addr - 8'(i2)));
      emit(enc_mov_imm(3'd2, 8'(rnd(256))));
      emit(enc_alu(2'b11, 3'd0, 3'd2, 2'(rnd(4)), 3'd2));
      emit(enc_mem(3'b100, 3'd1, 3'd2, 5'(i1)));
      emit(enc_mem(3'b011, 3'd4, 3'd3, 5'(i2)));
      emit(enc_mov_reg(3'd5, 3'd3, 2'd0));
      emit(16'he000);
      run_and_compare();
    end
    end_test();

    begin_test("random_program");
    build_random_program(12 + rnd(9));
    run_and_compare();
    end_test();

    begin_test("reset_and_reload");
    build_random_program(10);
    load_image();
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(negedge clk);
    // the reload resets the core in the middle of this program
    build_random_program(8 + rnd(8));
    run_and_compare();
    // reset again while sitting in halt
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("halted after reset", 16'h0, {15'b0, halted});
    end_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule: tb_cpu_top

// ==== src/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  input  isa_pkg::addr_t start_pc,
  input  logic           prog_w_en,
  input  isa_pkg::addr_t prog_addr,
  input  isa_pkg::word_t prog_data,
  output isa_pkg::word_t out,
  output logic           z,
  output logic           n,
  output logic           v,
  output logic           halted
);

  isa_pkg::addr_t cpu_addr;
  isa_pkg::word_t cpu_w_data;
  logic           cpu_w_en;
  isa_pkg::addr_t ram_addr;
  isa_pkg::word_t ram_w_data;
  logic           ram_w_en;
  isa_pkg::word_t ram_r_data;

  // loader owns the ram while the core is held in reset
  assign ram_w_en   = rst_n ? cpu_w_en : prog_w_en;
  assign ram_addr   = rst_n ? cpu_addr : prog_addr;
  assign ram_w_data = rst_n ? cpu_w_data : prog_data;

  cpu i_cpu (
    .clk(clk), .rst_n(rst_n), .start_pc(start_pc), .ram_r_data(ram_r_data),
    .ram_addr(cpu_addr), .ram_w_data(cpu_w_data), .ram_w_en(cpu_w_en),
    .out(out), .z(z), .n(n), .v(v), .halted(halted)
  );

  ram i_ram (
    .clk(clk), .w_en(ram_w_en), .addr(ram_addr), .w_data(ram_w_data), .r_data(ram_r_data)
  );

endmodule: cpu_top

// ==== src/ram.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module ram (
  input  logic           clk,
  input  logic           w_en,
  input  isa_pkg::addr_t addr,
  input  isa_pkg::word_t w_data,
  output isa_pkg::word_t r_data
);

  isa_pkg::word_t mem [`CPU_RAM_DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[addr] <= w_data;
    end
    r_data <= mem[addr];
  end

endmodule: ram

// ==== src/cpu.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu (
  input  logic           clk,
  input  logic           rst_n,
  input  isa_pkg::addr_t start_pc,
  input  isa_pkg::word_t ram_r_data,
  output isa_pkg::addr_t ram_addr,
  output isa_pkg::word_t ram_w_data,
  output logic           ram_w_en,
  output isa_pkg::word_t out,
  output logic           z,
  output logic           n,
  output logic           v,
  output logic           halted
);

  isa_pkg::addr_t     pc;
  isa_pkg::addr_t     next_pc;
  isa_pkg::addr_t     data_addr;
  isa_pkg::word_t     ir;
  isa_pkg::opcode_e   opcode;
  isa_pkg::alu_op_e   alu_op;
  isa_pkg::shift_op_e shift_op;
  isa_pkg::word_t     sximm5;
  isa_pkg::word_t     sximm8;
  isa_pkg::reg_idx_t  r_addr;
  isa_pkg::reg_idx_t  w_addr;
  ctrl_pkg::reg_sel_e reg_sel;
  logic               load_pc;
  logic               clear_pc;
  logic               load_ir;
  logic               load_addr;
  logic               sel_addr;

  dp_ctrl_if ctl ();

  assign next_pc    = clear_pc ? start_pc : pc + 1'b1;
  assign ram_addr   = sel_addr ? pc : data_addr;
  assign ram_w_data = out;

  always_ff @(posedge clk) begin
    if (load_pc) begin
      pc <= next_pc;
    end
    if (load_ir) begin
      ir <= ram_r_data;
    end
    if (load_addr) begin
      data_addr <= out[`CPU_ADDR_W-1:0];
    end
  end

  idecoder i_idecoder (
    .ir(ir), .reg_sel(reg_sel), .opcode(opcode), .alu_op(alu_op), .shift_op(shift_op),
    .sximm5(sximm5), .sximm8(sximm8), .r_addr(r_addr), .w_addr(w_addr)
  );

  controller i_controller (
    .clk(clk), .rst_n(rst_n), .opcode(opcode), .alu_op(alu_op), .ctl(ctl),
    .reg_sel(reg_sel), .load_pc(load_pc), .clear_pc(clear_pc), .load_ir(load_ir),
    .load_addr(load_addr), .sel_addr(sel_addr), .ram_w_en(ram_w_en), .halted(halted)
  );

  datapath i_datapath (
    .clk(clk), .ctl(ctl), .mdata(ram_r_data), .pc(pc), .r_addr(r_addr), .w_addr(w_addr),
    .shift_op(shift_op), .sximm5(sximm5), .sximm8(sximm8),
    .c(out), .z(z), .n(n), .v(v)
  );

endmodule: cpu

// ==== src/controller.sv ====
`timescale 1ns/10ps

module controller (
  input  logic               clk,
  input  logic               rst_n,
  input  isa_pkg::opcode_e   opcode,
  input  isa_pkg::alu_op_e   alu_op,
  dp_ctrl_if.ctrl            ctl,
  output ctrl_pkg::reg_sel_e reg_sel,
  output logic               load_pc,
  output logic               clear_pc,
  output logic               load_ir,
  output logic               load_addr,
  output logic               sel_addr,
  output logic               ram_w_en,
  output logic               halted
);

  ctrl_pkg::ctrl_state_e state;
  ctrl_pkg::ctrl_state_e state_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ctrl_pkg::fdr;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ctrl_pkg::fdr:    state_next = ctrl_pkg::stall1;
      ctrl_pkg::stall1: state_next = ctrl_pkg::stall2;
      ctrl_pkg::stall2: state_next = ctrl_pkg::fd;
      ctrl_pkg::fd: begin
        case (opcode)
          isa_pkg::op_alu: begin
            case (alu_op)
              isa_pkg::alu_sub: state_next = ctrl_pkg::cmp1;
              isa_pkg::alu_not: state_next = ctrl_pkg::mvn1;
              default:          state_next = ctrl_pkg::alu1;
            endcase
          end
          isa_pkg::op_mov: begin
            // subcode 10 is the immediate form
            if (alu_op == 2'b10) begin
              state_next = ctrl_pkg::movi;
            end else if (alu_op == isa_pkg::alu_add) begin
              state_next = ctrl_pkg::movr1;
            end
          end
          isa_pkg::op_ldr: begin
            if (alu_op == isa_pkg::alu_add) begin
              state_next = ctrl_pkg::ldr1;
            end
          end
          isa_pkg::op_str: begin
            if (alu_op == isa_pkg::alu_add) begin
              state_next = ctrl_pkg::str1;
            end
          end
          isa_pkg::op_halt: state_next = ctrl_pkg::halt;
          default:          state_next = ctrl_pkg::fd;
        endcase
      end
      ctrl_pkg::movi:  state_next = ctrl_pkg::stall1;
      ctrl_pkg::movr1: state_next = ctrl_pkg::movr2;
      ctrl_pkg::movr2: state_next = ctrl_pkg::movr3;
      ctrl_pkg::alu1:  state_next = ctrl_pkg::alu2;
      ctrl_pkg::alu2:  state_next = ctrl_pkg::alu3;
      ctrl_pkg::alu3:  state_next = ctrl_pkg::alu4;
      ctrl_pkg::cmp1:  state_next = ctrl_pkg::cmp2;
      ctrl_pkg::cmp2:  state_next = ctrl_pkg::cmp3;
      ctrl_pkg::mvn1:  state_next = ctrl_pkg::mvn2;
      ctrl_pkg::mvn2:  state_next = ctrl_pkg::mvn3;
      ctrl_pkg::ldr1:  state_next = ctrl_pkg::ldr2;
      ctrl_pkg::ldr2:  state_next = ctrl_pkg::ldr3;
      ctrl_pkg::ldr3:  state_next = ctrl_pkg::ldr4;
      ctrl_pkg::ldr4:  state_next = ctrl_pkg::ldr5;
      ctrl_pkg::str1:  state_next = ctrl_pkg::str2;
      ctrl_pkg::str2:  state_next = ctrl_pkg::str3;
      ctrl_pkg::str3:  state_next = ctrl_pkg::str4;
      ctrl_pkg::str4:  state_next = ctrl_pkg::str5;
      ctrl_pkg::halt:  state_next = ctrl_pkg::halt;
      default:         state_next = ctrl_pkg::fd;
    endcase
  end

  always_comb begin
    ctl.w_en      = 1'b0;
    ctl.en_a      = 1'b0;
    ctl.en_b      = 1'b0;
    ctl.en_c      = 1'b0;
    ctl.en_status = 1'b0;
    ctl.sel_a     = 1'b0;
    ctl.sel_b     = 1'b0;
    ctl.wb_sel    = ctrl_pkg::wb_c;
    ctl.alu_op    = isa_pkg::alu_add;
    reg_sel       = ctrl_pkg::sel_rm;
    load_pc       = 1'b0;
    clear_pc      = 1'b0;
    load_ir       = 1'b0;
    load_addr     = 1'b0;
    sel_addr      = 1'b1;
    ram_w_en      = 1'b0;
    case (state)
      ctrl_pkg::fdr: begin
        load_pc  = 1'b1;
        clear_pc = 1'b1;
      end
      // Rn goes into A here so that memory ops can form the address early
      ctrl_pkg::fd: begin
        reg_sel  = ctrl_pkg::sel_rn;
        ctl.en_a = 1'b1;
      end
      ctrl_pkg::movi: begin
        reg_sel    = ctrl_pkg::sel_rn;
        ctl.wb_sel = ctrl_pkg::wb_imm8;
        ctl.w_en   = 1'b1;
        load_pc    = 1'b1;
      end
      ctrl_pkg::movr1, ctrl_pkg::alu1, ctrl_pkg::cmp1, ctrl_pkg::mvn1: begin
        ctl.en_b = 1'b1;
        load_pc  = 1'b1;
      end
      ctrl_pkg::movr2, ctrl_pkg::str3: begin
        ctl.sel_a = 1'b1;
        ctl.en_c  = 1'b1;
      end
      ctrl_pkg::alu2: begin
        ctl.alu_op = alu_op;
        ctl.en_c   = 1'b1;
      end
      ctrl_pkg::mvn2: begin
        ctl.alu_op = isa_pkg::alu_not;
        ctl.sel_a  = 1'b1;
        ctl.en_c   = 1'b1;
      end
      ctrl_pkg::cmp2: begin
        ctl.alu_op    = isa_pkg::alu_sub;
        ctl.en_status = 1'b1;
      end
      ctrl_pkg::alu3: begin
        reg_sel  = ctrl_pkg::sel_rd;
        ctl.w_en = 1'b1;
      end
      ctrl_pkg::movr3, ctrl_pkg::mvn3: begin
        reg_sel  = ctrl_pkg::sel_rd;
        ctl.w_en = 1'b1;
        load_ir  = 1'b1;
      end
      ctrl_pkg::stall2, ctrl_pkg::alu4, ctrl_pkg::cmp3, ctrl_pkg::ldr5: begin
        load_ir = 1'b1;
      end
      // Rn plus imm5 into C, str also latches Rd into B
      ctrl_pkg::ldr1, ctrl_pkg::str1: begin
        ctl.sel_b = 1'b1;
        ctl.en_c  = 1'b1;
        load_pc   = 1'b1;
        reg_sel   = ctrl_pkg::sel_rd;
        ctl.en_b  = (state == ctrl_pkg::str1);
      end
      ctrl_pkg::ldr2, ctrl_pkg::str2: begin
        load_addr = 1'b1;
      end
      ctrl_pkg::ldr3: begin
        sel_addr = 1'b0;
      end
      ctrl_pkg::ldr4: begin
        reg_sel    = ctrl_pkg::sel_rd;
        ctl.wb_sel = ctrl_pkg::wb_mem;
        ctl.w_en   = 1'b1;
      end
      ctrl_pkg::str5: begin
        sel_addr = 1'b0;
        ram_w_en = 1'b1;
        load_ir  = 1'b1;
      end
      default: begin
        load_ir = 1'b0;
      end
    endcase
  end

  assign halted = (state == ctrl_pkg::halt);

endmodule: controller

// ==== src/idecoder.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module idecoder (
  input  isa_pkg::word_t     ir,
  input  ctrl_pkg::reg_sel_e reg_sel,
  output isa_pkg::opcode_e   opcode,
  output isa_pkg::alu_op_e   alu_op,
  output isa_pkg::shift_op_e shift_op,
  output isa_pkg::word_t     sximm5,
  output isa_pkg::word_t     sximm8,
  output isa_pkg::reg_idx_t  r_addr,
  output isa_pkg::reg_idx_t  w_addr
);

  assign opcode = isa_pkg::opcode_e'(ir[15:13]);
  assign alu_op = isa_pkg::alu_op_e'(ir[12:11]);

  // bits 4:3 are part of imm5 in memory instructions
  assign shift_op = (opcode == isa_pkg::op_ldr || opcode == isa_pkg::op_str) ?
                    isa_pkg::sh_none : isa_pkg::shift_op_e'(ir[4:3]);

  assign sximm5 = {{(`CPU_WORD_W-5){ir[4]}}, ir[4:0]};
  assign sximm8 = {{(`CPU_WORD_W-8){ir[7]}}, ir[7:0]};

  always_comb begin
    case (reg_sel)
      ctrl_pkg::sel_rd: r_addr = ir[7:5];
      ctrl_pkg::sel_rn: r_addr = ir[10:8];
      default:          r_addr = ir[2:0];
    endcase
  end

  // reads and writes always target the same selected field
  assign w_addr = r_addr;

endmodule: idecoder

// ==== src/datapath.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module datapath (
  input  logic               clk,
  dp_ctrl_if.dp              ctl,
  input  isa_pkg::word_t     mdata,
  input  isa_pkg::addr_t     pc,
  input  isa_pkg::reg_idx_t  r_addr,
  input  isa_pkg::reg_idx_t  w_addr,
  input  isa_pkg::shift_op_e shift_op,
  input  isa_pkg::word_t     sximm5,
  input  isa_pkg::word_t     sximm8,
  output isa_pkg::word_t     c,
  output logic               z,
  output logic               n,
  output logic               v
);

  isa_pkg::word_t regs [`CPU_NUM_REGS];
  isa_pkg::word_t r_data;
  isa_pkg::word_t w_data;
  isa_pkg::word_t a;
  isa_pkg::word_t b;
  isa_pkg::word_t b_shift;
  isa_pkg::word_t val_a;
  isa_pkg::word_t val_b;
  isa_pkg::word_t alu_result;
  logic           alu_z;
  logic           alu_n;
  logic           alu_v;
  logic [2:0]     status;

  // register file, one write port and one combinational read port
  always_ff @(posedge clk) begin
    if (ctl.w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  assign r_data = regs[r_addr];

  always_comb begin
    case (shift_op)
      isa_pkg::sh_lsl: b_shift = {b[`CPU_WORD_W-2:0], 1'b0};
      isa_pkg::sh_lsr: b_shift = {1'b0, b[`CPU_WORD_W-1:1]};
      isa_pkg::sh_asr: b_shift = {b[`CPU_WORD_W-1], b[`CPU_WORD_W-1:1]};
      default:         b_shift = b;
    endcase
  end

  assign val_a = ctl.sel_a ? '0 : a;
  assign val_b = ctl.sel_b ? sximm5 : b_shift;

  always_comb begin
    case (ctl.wb_sel)
      ctrl_pkg::wb_pc:   w_data = {{(`CPU_WORD_W-`CPU_ADDR_W){1'b0}}, pc};
      ctrl_pkg::wb_imm8: w_data = sximm8;
      ctrl_pkg::wb_mem:  w_data = mdata;
      default:           w_data = c;
    endcase
  end

  alu i_alu (
    .val_a  (val_a),
    .val_b  (val_b),
    .alu_op (ctl.alu_op),
    .result (alu_result),
    .z      (alu_z),
    .n      (alu_n),
    .v      (alu_v)
  );

  always_ff @(posedge clk) begin
    if (ctl.en_a) begin
      a <= r_data;
    end
    if (ctl.en_b) begin
      b <= r_data;
    end
    if (ctl.en_c) begin
      c <= alu_result;
    end
    if (ctl.en_status) begin
      status <= {alu_z, alu_n, alu_v};
    end
  end

  assign z = status[2];
  assign n = status[1];
  assign v = status[0];

endmodule: datapath

// ==== src/alu.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module alu (
  input  isa_pkg::word_t   val_a,
  input  isa_pkg::word_t   val_b,
  input  isa_pkg::alu_op_e alu_op,
  output isa_pkg::word_t   result,
  output logic             z,
  output logic             n,
  output logic             v
);

  always_comb begin
    v = 1'b0;
    case (alu_op)
      isa_pkg::alu_add: begin
        result = val_a + val_b;
        // same-sign operands giving a different-sign sum
        v = (val_a[`CPU_WORD_W-1] == val_b[`CPU_WORD_W-1]) &&
            (result[`CPU_WORD_W-1] != val_a[`CPU_WORD_W-1]);
      end
      isa_pkg::alu_sub: begin
        result = val_a - val_b;
        v = (val_a[`CPU_WORD_W-1] != val_b[`CPU_WORD_W-1]) &&
            (result[`CPU_WORD_W-1] != val_a[`CPU_WORD_W-1]);
      end
      isa_pkg::alu_and: begin
        result = val_a & val_b;
      end
      default: begin
        result = ~val_b;
      end
    endcase
  end

  assign z = (result == '0);
  assign n = result[`CPU_WORD_W-1];

endmodule: alu

// ==== src/dp_ctrl_if.sv ====
`timescale 1ns/10ps

interface dp_ctrl_if ();
  logic              w_en;
  logic              en_a;
  logic              en_b;
  logic              en_c;
  logic              en_status;
  logic              sel_a;
  logic              sel_b;
  ctrl_pkg::wb_sel_e wb_sel;
  isa_pkg::alu_op_e  alu_op;

  modport ctrl (
    output w_en, en_a, en_b, en_c, en_status,
    output sel_a, sel_b, wb_sel, alu_op
  );

  modport dp (
    input w_en, en_a, en_b, en_c, en_status,
    input sel_a, sel_b, wb_sel, alu_op
  );
endinterface: dp_ctrl_if

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

  // fd is fetch and decode, fdr is the reset entry
  typedef enum logic [5:0] {
    fdr, stall1, stall2, fd, halt,
    movi, movr1, movr2, movr3,
    alu1, alu2, alu3, alu4,
    cmp1, cmp2, cmp3,
    mvn1, mvn2, mvn3,
    ldr1, ldr2, ldr3, ldr4, ldr5,
    str1, str2, str3, str4, str5
  } ctrl_state_e;

  typedef enum logic [1:0] {
    sel_rm = 2'b00,
    sel_rd = 2'b01,
    sel_rn = 2'b10
  } reg_sel_e;

  typedef enum logic [1:0] {
    wb_c    = 2'b00,
    wb_pc   = 2'b01,
    wb_imm8 = 2'b10,
    wb_mem  = 2'b11
  } wb_sel_e;

endpackage: ctrl_pkg

// ==== src/isa_pkg.sv ====
`include "cpu_cfg.svh"

package isa_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

  // instruction bits 15:13
  typedef enum logic [2:0] {
    op_ldr  = 3'b011,
    op_str  = 3'b100,
    op_alu  = 3'b101,
    op_mov  = 3'b110,
    op_halt = 3'b111
  } opcode_e;

  // instruction bits 12:11
  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_and = 2'b10,
    alu_not = 2'b11
  } alu_op_e;

  // instruction bits 4:3, shift by one
  typedef enum logic [1:0] {
    sh_none = 2'b00,
    sh_lsl  = 2'b01,
    sh_lsr  = 2'b10,
    sh_asr  = 2'b11
  } shift_op_e;

endpackage: isa_pkg

// ==== src/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// fixed by the instruction set
`define CPU_WORD_W 16
`define CPU_ADDR_W 8

// register file and memory sizes
`define CPU_NUM_REGS 8
`define CPU_RAM_DEPTH 256

`endif
